/* filelist.f */
hw/rv_isa_pkg.sv
hw/rv_bus_pkg.sv
hw/rv_decoder.sv
hw/rv_regfile.sv
hw/rv_alu.sv
hw/rv_branch_unit.sv
hw/rv_apb_mem.sv
hw/rv_commit.sv
hw/rv_top.sv
tb/rv_tb_props.sv
tb/rv_tb.sv

/* hw/rv_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_alu import rv_isa_pkg::*; (
  input  decoded_t    dec,
  input  logic [31:0] pc,
  input  logic [31:0] rdata1,
  input  logic [31:0] rdata2,
  output alu_res_t    res
);

  logic [31:0] op_a;
  logic [31:0] op_b;

  // auipc takes pc, immediate forms and memory ops take imm
  assign op_a = dec.a_is_pc  ? pc      : rdata1;
  assign op_b = dec.b_is_imm ? dec.imm : rdata2;

  always_comb begin
    case (dec.alu_op)
      ALU_ADD:    res.value = op_a + op_b;
      ALU_SUB:    res.value = op_a - op_b;
      ALU_AND:    res.value = op_a & op_b;
      ALU_OR:     res.value = op_a | op_b;
      ALU_XOR:    res.value = op_a ^ op_b;
      // signed compare
      ALU_SLT:    res.value = {31'd0, $signed(op_a) < $signed(op_b)};
      ALU_PASS_B: res.value = op_b;
      default:    res.value = 32'd0;
    endcase
  end

endmodule

`default_nettype wire

/* hw/rv_apb_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_apb_mem import rv_isa_pkg::*, rv_bus_pkg::*; #(
  parameter int MEM_WORDS = 256
) (
  input  logic        clk,
  input  logic        rst_n,
  input  apb_req_t    apb_req,
  output apb_rsp_t    apb_rsp,
  input  logic [31:0] pc,
  output logic [31:0] instr,
  input  mem_port_t   dmem,
  output logic [31:0] mem_rdata,
  input  core_state_e state,
  output logic        start
);

  localparam int AW = $clog2(MEM_WORDS);

  logic [31:0] mem [MEM_WORDS];
  logic        access;
  logic        is_mem;
  logic        wr_err;
  logic        apb_mem_wr;
  logic [31:0] status;
  logic        start_q;

  // access phase of a transfer, zero wait
  assign access = apb_req.psel && apb_req.penable;
  assign is_mem = (apb_req.paddr < ADDR_CTRL);

  // memory busy while running, status and pc are read only
  assign wr_err = apb_req.pwrite && ((is_mem && state == ST_RUN) ||
                  apb_req.paddr == ADDR_STATUS || apb_req.paddr == ADDR_PC);

  assign apb_rsp.pready  = 1'b1;
  assign apb_rsp.pslverr = access && (apb_req.paddr >= ADDR_END || wr_err);

  assign apb_mem_wr = access && apb_req.pwrite && is_mem && !apb_rsp.pslverr;

  // start taken at the end of the ctrl write access phase
  assign start = access && apb_req.pwrite && apb_req.paddr == ADDR_CTRL &&
                 apb_req.pwdata[0];

  assign status = {29'd0, state == ST_FAULT, state == ST_HALT, state == ST_RUN};

  always_comb begin
    if (is_mem) begin
      apb_rsp.prdata = mem[apb_req.paddr[AW+1:2]];
    end else if (apb_req.paddr == ADDR_CTRL) begin
      // ctrl reads back the last start request
      apb_rsp.prdata = {31'd0, start_q};
    end else if (apb_req.paddr == ADDR_STATUS) begin
      apb_rsp.prdata = status;
    end else if (apb_req.paddr == ADDR_PC) begin
      apb_rsp.prdata = pc;
    end else begin
      apb_rsp.prdata = 32'd0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      start_q <= 1'b0;
    end else if (access && apb_req.pwrite && apb_req.paddr == ADDR_CTRL) begin
      start_q <= apb_req.pwdata[0];
    end
  end

  // fetch and load ports, word addressed
  assign instr     = mem[pc[AW+1:2]];
  assign mem_rdata = mem[dmem.addr[AW+1:2]];

  // single write port, core owns it in run, apb otherwise
  always_ff @(posedge clk) begin
    if (state == ST_RUN) begin
      if (dmem.wen) begin
        mem[dmem.addr[AW+1:2]] <= dmem.wdata;
      end
    end else if (apb_mem_wr) begin
      mem[apb_req.paddr[AW+1:2]] <= apb_req.pwdata;
    end
  end

endmodule

`default_nettype wire

/* hw/rv_branch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_branch_unit import rv_isa_pkg::*; (
  input  decoded_t    dec,
  input  logic [31:0] pc,
  input  logic [31:0] rdata1,
  input  logic [31:0] rdata2,
  output br_res_t     res
);

  logic eq;
  logic lt;

  assign eq = (rdata1 == rdata2);
  assign lt = ($signed(rdata1) < $signed(rdata2));

  always_comb begin
    case (dec.br_op)
      BR_EQ:           res.taken = eq;
      BR_NE:           res.taken = !eq;
      BR_LT:           res.taken = lt;
      // jumps always redirect
      BR_JAL, BR_JALR: res.taken = 1'b1;
      default:         res.taken = 1'b0;
    endcase
  end

  // jalr is register relative with bit 0 cleared, all others pc relative
  assign res.target = (dec.br_op == BR_JALR) ? ((rdata1 + dec.imm) & ~32'd1)
                                             : (pc + dec.imm);

endmodule

`default_nettype wire

/* hw/rv_bus_pkg.sv */
`default_nettype none

package rv_bus_pkg;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  // register map, memory words sit below ctrl
  parameter logic [11:0] ADDR_CTRL   = 12'h400;
  parameter logic [11:0] ADDR_STATUS = 12'h404;
  parameter logic [11:0] ADDR_PC     = 12'h408;
  parameter logic [11:0] ADDR_END    = 12'h40C;

  // data request from commit to memory
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        wen;
  } mem_port_t;

endpackage

`default_nettype wire

/* hw/rv_commit.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_commit import rv_isa_pkg::*, rv_bus_pkg::*; #(
  parameter int MEM_WORDS = 256
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        start,
  input  decoded_t    dec,
  input  alu_res_t    alu,
  input  br_res_t     br,
  input  logic [31:0] rdata2,
  input  logic [31:0] mem_rdata,
  output logic [31:0] pc,
  output core_state_e state,
  output logic        wb_en,
  output logic [4:0]  wb_addr,
  output logic [31:0] wb_data,
  output mem_port_t   dmem
);

  localparam logic [31:0] MEM_BYTES = 32'(MEM_WORDS * 4);

  logic [31:0] pc_plus4;
  logic [31:0] next_pc;
  logic        pc_oob;
  logic        fault_now;
  logic        retire;
  logic        is_jump;

  assign pc_plus4  = pc + 32'd4;
  assign pc_oob    = (pc >= MEM_BYTES);
  assign fault_now = dec.illegal || pc_oob;

  // an instruction retires only in run without a fault
  assign retire  = (state == ST_RUN) && !fault_now;
  assign is_jump = (dec.br_op == BR_JAL) || (dec.br_op == BR_JALR);

  // writes to x0 dropped here
  assign wb_en   = retire && dec.reg_wen && (dec.rd != 5'd0);
  assign wb_addr = dec.rd;
  // link value, load data or alu value
  assign wb_data = is_jump ? pc_plus4 : (dec.mem_ren ? mem_rdata : alu.value);

  // store address from alu, data straight from rs2
  assign dmem.addr  = alu.value;
  assign dmem.wdata = rdata2;
  assign dmem.wen   = retire && dec.mem_wen;

  assign next_pc = br.taken ? br.target : pc_plus4;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ST_IDLE;
      pc    <= 32'd0;
    end else if (start) begin
      // restart from 0, registers keep their contents
      state <= ST_RUN;
      pc    <= 32'd0;
    end else if (state == ST_RUN) begin
      // fault and halt both hold pc on the offending word
      if (fault_now) begin
        state <= ST_FAULT;
      end else if (dec.is_ebreak) begin
        state <= ST_HALT;
      end else begin
        pc <= next_pc;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/rv_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_decoder import rv_isa_pkg::*; (
  input  logic [31:0] instr,
  output decoded_t    dec
);

  opcode_e     opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;

  assign opcode = opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // immediate formats, all sign extended from bit 31
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    dec        = '0;
    dec.rd     = instr[11:7];
    dec.rs1    = instr[19:15];
    dec.rs2    = instr[24:20];
    dec.alu_op = ALU_ADD;
    dec.br_op  = BR_NONE;
    case (opcode)
      OP_LUI: begin
        dec.imm      = imm_u;
        dec.alu_op   = ALU_PASS_B;
        dec.b_is_imm = 1'b1;
        dec.reg_wen  = 1'b1;
      end
      OP_AUIPC: begin
        dec.imm      = imm_u;
        dec.a_is_pc  = 1'b1;
        dec.b_is_imm = 1'b1;
        dec.reg_wen  = 1'b1;
      end
      OP_IMM, OP_OP: begin
        dec.imm      = imm_i;
        dec.b_is_imm = (opcode == OP_IMM);
        dec.reg_wen  = 1'b1;
        case (funct3)
          3'b000:  dec.alu_op = ALU_ADD;
          3'b010:  dec.alu_op = ALU_SLT;
          3'b100:  dec.alu_op = ALU_XOR;
          3'b110:  dec.alu_op = ALU_OR;
          3'b111:  dec.alu_op = ALU_AND;
          default: dec.illegal = 1'b1;
        endcase
        // register form: funct7 zero, or sub with funct7 0x20
        if (opcode == OP_OP) begin
          if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
            dec.alu_op = ALU_SUB;
          end else if (funct7 != 7'b0000000) begin
            dec.illegal = 1'b1;
          end
        end
      end
      OP_LOAD: begin
        // lw only
        dec.imm      = imm_i;
        dec.b_is_imm = 1'b1;
        dec.mem_ren  = 1'b1;
        dec.reg_wen  = 1'b1;
        dec.illegal  = (funct3 != 3'b010);
      end
      OP_STORE: begin
        dec.imm      = imm_s;
        dec.b_is_imm = 1'b1;
        dec.mem_wen  = 1'b1;
        dec.illegal  = (funct3 != 3'b010);
      end
      OP_BRANCH: begin
        dec.imm = imm_b;
        case (funct3)
          3'b000:  dec.br_op = BR_EQ;
          3'b001:  dec.br_op = BR_NE;
          3'b100:  dec.br_op = BR_LT;
          default: dec.illegal = 1'b1;
        endcase
      end
      OP_JAL: begin
        dec.imm     = imm_j;
        dec.br_op   = BR_JAL;
        dec.reg_wen = 1'b1;
      end
      OP_JALR: begin
        dec.imm     = imm_i;
        dec.br_op   = BR_JALR;
        dec.reg_wen = 1'b1;
        dec.illegal = (funct3 != 3'b000);
      end
      OP_SYSTEM: begin
        // ebreak is the only system encoding accepted
        dec.is_ebreak = (instr == 32'h0010_0073);
        dec.illegal   = (instr != 32'h0010_0073);
      end
      default: dec.illegal = 1'b1;
    endcase
    // an illegal word must not touch architectural state
    if (dec.illegal) begin
      dec.reg_wen = 1'b0;
      dec.mem_wen = 1'b0;
      dec.mem_ren = 1'b0;
      dec.br_op   = BR_NONE;
    end
  end

endmodule

`default_nettype wire

/* hw/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

  // major opcodes of the supported rv32i subset
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_IMM    = 7'b0010011,
    OP_OP     = 7'b0110011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_BRANCH = 7'b1100011,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  // pass_b forwards operand b, used by lui
  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_PASS_B
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NONE, BR_EQ, BR_NE, BR_LT, BR_JAL, BR_JALR
  } br_op_e;

  typedef enum logic [1:0] {
    ST_IDLE, ST_RUN, ST_HALT, ST_FAULT
  } core_state_e;

  typedef struct packed {
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;
    alu_op_e     alu_op;
    br_op_e      br_op;
    logic        a_is_pc;
    logic        b_is_imm;
    logic        reg_wen;
    logic        mem_ren;
    logic        mem_wen;
    logic        is_ebreak;
    logic        illegal;
  } decoded_t;

  typedef struct packed {
    logic [31:0] value;
  } alu_res_t;

  typedef struct packed {
    logic        taken;
    logic [31:0] target;
  } br_res_t;

endpackage

`default_nettype wire

/* hw/rv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  input  logic [4:0]  wb_addr,
  input  logic        wb_en,
  input  logic [31:0] wb_data,
  output logic [31:0] rdata1,
  output logic [31:0] rdata2
);

  logic [31:0] regs [32];

  // x0 never written, so it stays at the reset value
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regs <= '{default: '0};
    end else if (wb_en && wb_addr != 5'd0) begin
      regs[wb_addr] <= wb_data;
    end
  end

  // reads are combinational, no bypass needed in single cycle
  assign rdata1 = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
  assign rdata2 = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

endmodule

`default_nettype wire

/* hw/rv_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_top import rv_isa_pkg::*, rv_bus_pkg::*; #(
  parameter int MEM_WORDS = 256
) (
  input  logic     clk,
  input  logic     rst_n,
  input  apb_req_t apb_req,
  output apb_rsp_t apb_rsp
);

  decoded_t    dec;
  alu_res_t    alu_res;
  br_res_t     br_res;
  mem_port_t   dmem;
  core_state_e state;
  logic        start;
  logic [31:0] pc;
  logic [31:0] instr;
  logic [31:0] mem_rdata;
  logic [31:0] rdata1;
  logic [31:0] rdata2;
  logic        wb_en;
  logic [4:0]  wb_addr;
  logic [31:0] wb_data;

  // unified memory plus apb register block
  rv_apb_mem #(.MEM_WORDS(MEM_WORDS)) i_apb_mem (
    .clk, .rst_n, .apb_req, .apb_rsp, .pc, .instr, .dmem, .mem_rdata, .state, .start
  );

  rv_decoder i_decoder (.instr, .dec);

  rv_regfile i_regfile (
    .clk, .rst_n, .rs1(dec.rs1), .rs2(dec.rs2),
    .wb_addr, .wb_en, .wb_data, .rdata1, .rdata2
  );

  // alu and branch unit in parallel
  rv_alu i_alu (.dec, .pc, .rdata1, .rdata2, .res(alu_res));

  rv_branch_unit i_branch_unit (.dec, .pc, .rdata1, .rdata2, .res(br_res));

  rv_commit #(.MEM_WORDS(MEM_WORDS)) i_commit (
    .clk, .rst_n, .start, .dec, .alu(alu_res), .br(br_res), .rdata2, .mem_rdata,
    .pc, .state, .wb_en, .wb_addr, .wb_data, .dmem
  );

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# build and run the rv_tb regression with verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal --top-module rv_tb \
    -f filelist.f -o rv_sim; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/rv_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Regression failed" "$LOG"; then
  exit 1
fi

if ! grep -q "Regression passed" "$LOG"; then
  echo "no final result found in $LOG"
  exit 1
fi

exit 0

/* tb/rv_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_tb import rv_isa_pkg::*, rv_bus_pkg::*; ();

  // apb traffic stays well under 1500 cycles, programs under 100 instructions
  localparam int TIMEOUT_CYCLES = 4000;
  localparam logic [31:0] EBREAK = 32'h0010_0073;

  logic        clk;
  logic        rst_n;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  logic [31:0] rng_state = 32'd37;
  logic [31:0] prog [$];
  logic [31:0] expected [$];
  int          checks = 0;
  int          errors = 0;
  int          cycle_count = 0;

  rv_top #(.MEM_WORDS(256)) i_rv_top (.clk, .rst_n, .apb_req, .apb_rsp);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
      $display("Regression failed");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic logic [31:0] rand_word();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic logic [31:0] sext12(input logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  // instruction encoders, one per rv32i format
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OP_OP};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] off, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
    return {off[11:5], rs2, rs1, 3'b010, off[4:0], OP_STORE};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
  endfunction

  // status bits: 0 run, 1 halt, 2 fault
  function automatic core_state_e state_of(input logic [31:0] s);
    case (s)
      32'd1:   return ST_RUN;
      32'd2:   return ST_HALT;
      32'd4:   return ST_FAULT;
      default: return ST_IDLE;
    endcase
  endfunction

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_state(input string name, input core_state_e exp,
                             input core_state_e act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s expected %s actual %s", $time, name, exp.name(),
               act.name());
    end
  endtask

  task automatic check_slverr(input string what, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("At %0t ns the %s gave pslverr %b where %b was due", $time, what, act, exp);
    end
  endtask

  // setup then access, sampled mid access, bus idle afterwards
  task automatic apb_transfer(input logic write, input logic [11:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
    apb_req_t req;
    req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
    @(posedge clk);
    apb_req <= req;
    req.penable = 1'b1;
    @(posedge clk);
    apb_req <= req;
    @(negedge clk);
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    // zero wait slave, ready in every access phase
    check_word("pready", 32'd1, {31'd0, apb_rsp.pready});
    @(posedge clk);
    apb_req <= '0;
  endtask

  task automatic apb_write(input logic [11:0] addr, input logic [31:0] data, output logic err);
    logic [31:0] unused;
    apb_transfer(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input logic [11:0] addr, output logic [31:0] data, output logic err);
    apb_transfer(1'b0, addr, 32'd0, data, err);
  endtask

  task automatic write_ok(input logic [11:0] addr, input logic [31:0] data);
    logic err;
    apb_write(addr, data, err);
    check_slverr($sformatf("write to %h", addr), 1'b0, err);
  endtask

  task automatic read_word(input logic [11:0] addr, output logic [31:0] data);
    logic err;
    apb_read(addr, data, err);
    check_slverr($sformatf("read of %h", addr), 1'b0, err);
  endtask

  task automatic expect_mem(input logic [11:0] addr, input logic [31:0] exp, input string name);
    logic [31:0] v;
    read_word(addr, v);
    check_word(name, exp, v);
  endtask

  task automatic expect_status(input core_state_e exp);
    logic [31:0] s;
    read_word(ADDR_STATUS, s);
    if (!(s inside {32'd0, 32'd1, 32'd2, 32'd4})) begin
      errors++;
      $display("At %0t ns the status register held %h, which is no valid state", $time, s);
    end else begin
      check_state("status", exp, state_of(s));
    end
  endtask

  // lui plus addi, upper part rounded for the sign extended low part
  task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] upper;
    upper = (value + 32'h800) >> 12;
    prog.push_back(u_type(upper[19:0], rd, OP_LUI));
    prog.push_back(i_type(value[11:0], rd, 3'b000, rd, OP_IMM));
  endtask

  // result in x3, stored to the next slot from 0x200
  task automatic emit_checked(input logic [31:0] instr, input logic [31:0] value);
    logic [11:0] slot;
    slot = 12'h200 + 12'(4 * expected.size());
    prog.push_back(instr);
    prog.push_back(s_type(slot, 5'd3, 5'd0));
    expected.push_back(value);
  endtask

  task automatic load_program();
    foreach (prog[i]) write_ok(12'(4 * i), prog[i]);
  endtask

  // start at pc 0, poll until halt or fault
  task automatic run_to_stop();
    logic [31:0] s;
    write_ok(ADDR_CTRL, 32'd1);
    s = 32'd0;
    while (!(s[1] || s[2])) read_word(ADDR_STATUS, s);
  endtask

  task automatic access_checks();
    logic [31:0] data [16];
    logic [31:0] v;
    logic        err;
    expect_status(ST_IDLE);
    expect_mem(ADDR_PC, 32'd0, "pc after reset");
    foreach (data[i]) begin
      data[i] = rand_word();
      write_ok(12'h100 + 12'(4 * i), data[i]);
    end
    foreach (data[i]) expect_mem(12'h100 + 12'(4 * i), data[i], $sformatf("mem word %0d", i));
    // unmapped and read only addresses
    apb_read(ADDR_END, v, err);
    check_slverr("read of 0x40c", 1'b1, err);
    apb_read(12'hFFC, v, err);
    check_slverr("read of 0xffc", 1'b1, err);
    apb_write(ADDR_STATUS, 32'd1, err);
    check_slverr("write to status", 1'b1, err);
    apb_write(ADDR_PC, 32'h40, err);
    check_slverr("write to pc", 1'b1, err);
    expect_status(ST_IDLE);
  endtask

  task automatic arith_program();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    logic [11:0] imm;
    prog.delete();
    expected.delete();
    a = rand_word();
    b = rand_word();
    r = rand_word();
    imm = r[11:0];
    load_const(5'd1, a);
    load_const(5'd2, b);
    emit_checked(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), a + b);
    emit_checked(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd3), a - b);
    emit_checked(r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd3), a & b);
    emit_checked(r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd3), a | b);
    emit_checked(r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd3), a ^ b);
    emit_checked(r_type(7'h00, 5'd2, 5'd1, 3'b010, 5'd3), {31'd0, $signed(a) < $signed(b)});
    emit_checked(r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd3), {31'd0, $signed(b) < $signed(a)});
    // immediate forms
    emit_checked(i_type(imm, 5'd1, 3'b000, 5'd3, OP_IMM), a + sext12(imm));
    emit_checked(i_type(imm, 5'd1, 3'b111, 5'd3, OP_IMM), a & sext12(imm));
    emit_checked(i_type(imm, 5'd1, 3'b110, 5'd3, OP_IMM), a | sext12(imm));
    emit_checked(i_type(imm, 5'd1, 3'b100, 5'd3, OP_IMM), a ^ sext12(imm));
    emit_checked(i_type(imm, 5'd2, 3'b010, 5'd3, OP_IMM),
                 {31'd0, $signed(b) < $signed(sext12(imm))});
    emit_checked(u_type(b[31:12], 5'd3, OP_LUI), {b[31:12], 12'd0});
    prog.push_back(EBREAK);
    load_program();
    run_to_stop();
    expect_status(ST_HALT);
    foreach (expected[k]) begin
      expect_mem(12'h200 + 12'(4 * k), expected[k], $sformatf("result %0d", k));
    end
  endtask

  task automatic memory_program();
    logic [31:0] w0;
    logic [31:0] w1;
    int          auipc_pc;
    int          ebreak_pc;
    w0 = rand_word();
    w1 = rand_word();
    write_ok(12'h300, w0);
    write_ok(12'h304, w1);
    prog.delete();
    prog.push_back(i_type(12'h300, 5'd0, 3'b010, 5'd1, OP_LOAD));
    prog.push_back(i_type(12'h300, 5'd0, 3'b000, 5'd5, OP_IMM));
    // lw and sw with a base register
    prog.push_back(i_type(12'h004, 5'd5, 3'b010, 5'd2, OP_LOAD));
    prog.push_back(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
    prog.push_back(s_type(12'h310, 5'd3, 5'd0));
    prog.push_back(s_type(12'h014, 5'd2, 5'd5));
    auipc_pc = prog.size() * 4;
    prog.push_back(u_type(20'h12345, 5'd4, OP_AUIPC));
    prog.push_back(s_type(12'h318, 5'd4, 5'd0));
    ebreak_pc = prog.size() * 4;
    prog.push_back(EBREAK);
    load_program();
    run_to_stop();
    expect_status(ST_HALT);
    expect_mem(12'h310, w0 + w1, "sum of loaded words");
    expect_mem(12'h314, w1, "store via base register");
    expect_mem(12'h318, 32'(auipc_pc) + 32'h1234_5000, "auipc value");
    expect_mem(ADDR_PC, 32'(ebreak_pc), "pc at ebreak");
  endtask

  task automatic control_flow_program();
    logic [31:0] r;
    int          n;
    int          flag;
    int          jal_pc;
    int          jalr_pc;
    int          x3v;
    int          x6v;
    r = rand_word();
    n = 5 + int'(r[3:0]);
    x3v = 5;
    x6v = -3;
    // a taken branch skips the addi after it
    flag = ((x3v == x3v) ? 0 : 1) + ((x6v < x3v) ? 0 : 2) + ((x3v < x6v) ? 0 : 4) +
           ((x3v == x6v) ? 0 : 8) + ((x3v != x3v) ? 0 : 16);
    prog.delete();
    prog.push_back(i_type(12'd0, 5'd0, 3'b000, 5'd1, OP_IMM));
    prog.push_back(i_type(12'(n), 5'd0, 3'b000, 5'd2, OP_IMM));
    // loop body at word 2, count x2 down to zero
    prog.push_back(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd1));
    prog.push_back(i_type(12'hFFF, 5'd2, 3'b000, 5'd2, OP_IMM));
    prog.push_back(b_type(13'h1FF8, 5'd0, 5'd2, 3'b001));
    prog.push_back(s_type(12'h320, 5'd1, 5'd0));
    prog.push_back(i_type(12'(x3v), 5'd0, 3'b000, 5'd3, OP_IMM));
    prog.push_back(i_type(12'(x3v), 5'd0, 3'b000, 5'd4, OP_IMM));
    prog.push_back(i_type(12'(x6v), 5'd0, 3'b000, 5'd6, OP_IMM));
    prog.push_back(i_type(12'd0, 5'd0, 3'b000, 5'd5, OP_IMM));
    prog.push_back(b_type(13'd8, 5'd4, 5'd3, 3'b000));
    prog.push_back(i_type(12'd1, 5'd5, 3'b000, 5'd5, OP_IMM));
    prog.push_back(b_type(13'd8, 5'd3, 5'd6, 3'b100));
    prog.push_back(i_type(12'd2, 5'd5, 3'b000, 5'd5, OP_IMM));
    prog.push_back(b_type(13'd8, 5'd6, 5'd3, 3'b100));
    prog.push_back(i_type(12'd4, 5'd5, 3'b000, 5'd5, OP_IMM));
    prog.push_back(b_type(13'd8, 5'd6, 5'd3, 3'b000));
    prog.push_back(i_type(12'd8, 5'd5, 3'b000, 5'd5, OP_IMM));
    prog.push_back(b_type(13'd8, 5'd4, 5'd3, 3'b001));
    prog.push_back(i_type(12'd16, 5'd5, 3'b000, 5'd5, OP_IMM));
    prog.push_back(s_type(12'h324, 5'd5, 5'd0));
    // call at word 21 to the subroutine at word 26
    jal_pc = prog.size() * 4;
    prog.push_back(j_type(21'd20, 5'd7));
    prog.push_back(s_type(12'h328, 5'd7, 5'd0));
    prog.push_back(s_type(12'h32C, 5'd8, 5'd0));
    prog.push_back(s_type(12'h330, 5'd9, 5'd0));
    prog.push_back(EBREAK);
    prog.push_back(i_type(12'd77, 5'd0, 3'b000, 5'd8, OP_IMM));
    // return with offset 1, bit 0 of the target gets cleared
    jalr_pc = prog.size() * 4;
    prog.push_back(i_type(12'd1, 5'd7, 3'b000, 5'd9, OP_JALR));
    load_program();
    run_to_stop();
    expect_status(ST_HALT);
    expect_mem(12'h320, 32'(n * (n + 1) / 2), "loop sum");
    expect_mem(12'h324, 32'(flag), "branch flags");
    expect_mem(12'h328, 32'(jal_pc + 4), "jal link");
    expect_mem(12'h32C, 32'd77, "subroutine result");
    expect_mem(12'h330, 32'(jalr_pc + 4), "jalr link");
  endtask

  task automatic fault_scenarios();
    logic [31:0] sentinel;
    logic [31:0] r;
    logic        err;
    sentinel = rand_word();
    write_ok(12'h340, 32'd0);
    write_ok(12'h344, sentinel);
    prog.delete();
    prog.push_back(i_type(12'd1, 5'd0, 3'b000, 5'd1, OP_IMM));
    prog.push_back(s_type(12'h340, 5'd1, 5'd0));
    prog.push_back(32'hFFFF_FFFF);
    prog.push_back(s_type(12'h344, 5'd1, 5'd0));
    prog.push_back(EBREAK);
    load_program();
    run_to_stop();
    expect_status(ST_FAULT);
    expect_mem(ADDR_PC, 32'd8, "pc at illegal word");
    expect_mem(12'h340, 32'd1, "store before fault");
    expect_mem(12'h344, sentinel, "word after fault");
    // patch the illegal word, restart must begin at 0 again
    write_ok(12'h340, 32'd0);
    write_ok(12'h008, EBREAK);
    run_to_stop();
    expect_status(ST_HALT);
    expect_mem(ADDR_PC, 32'd8, "pc after restart");
    expect_mem(12'h340, 32'd1, "store after restart");
    // endless jal x0, 0 keeps the core in run
    r = rand_word();
    write_ok(12'h380, r);
    write_ok(12'h000, j_type(21'd0, 5'd0));
    write_ok(ADDR_CTRL, 32'd1);
    expect_status(ST_RUN);
    apb_write(12'h380, ~r, err);
    check_slverr("memory write while running", 1'b1, err);
    expect_mem(12'h380, r, "word guarded during run");
    expect_mem(ADDR_PC, 32'd0, "pc in loop");
  endtask

  initial begin
    rst_n = 1'b0;
    apb_req = '0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    access_checks();
    arith_program();
    memory_program();
    control_flow_program();
    fault_scenarios();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb/rv_tb_props.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_tb_props import rv_isa_pkg::*, rv_bus_pkg::*; (
  input logic        clk,
  input logic        rst_n,
  input apb_req_t    apb_req,
  input core_state_e state,
  input logic        start,
  input logic [31:0] pc,
  input logic        wb_en,
  input mem_port_t   dmem
);

  // setup phase always followed by its own access phase
  assert property (@(posedge clk) disable iff (!rst_n)
    (apb_req.psel && !apb_req.penable) |=>
      (apb_req.psel && apb_req.penable &&
       $stable(apb_req.paddr) && $stable(apb_req.pwrite)))
    else $error("apb setup phase not followed by a matching access phase");

  // start is a single cycle pulse
  assert property (@(posedge clk) disable iff (!rst_n)
    start |=> !start)
    else $error("start pulse longer than one cycle");

  // fetch stays word aligned, jalr only clears bit 0
  assert property (@(posedge clk) disable iff (!rst_n)
    (state == ST_RUN) |-> (pc[1:0] == 2'b00))
    else $error("pc not word aligned while running");

  // an instruction that writes never ends the run
  assert property (@(posedge clk) disable iff (!rst_n)
    ((state == ST_RUN) && (wb_en || dmem.wen) && !start) |=> (state == ST_RUN))
    else $error("core stopped on an instruction that wrote");

endmodule

// top level sees both the apb slave and the commit block
bind rv_top rv_tb_props i_rv_tb_props (
  .clk, .rst_n, .apb_req, .state, .start, .pc, .wb_en, .dmem
);

`default_nettype wire
